// File: tb.f
+incdir+.
order_tag_pkg.sv
mem_chan_pkg.sv
rsp_order_ctrl.sv
rd_reorder_buf.sv
wr_mdata_heap.sv
rsp_order_shim.sv
rsp_order_sva.sv
tb_rsp_order.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --assert -j 0
LINT_FLAGS = --lint-only --assert --timing
TOP = tb_rsp_order
FILELIST = tb.f
OBJ_DIR = obj_dir
PASS_MSG = Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_rsp_order.sv
`include "rsp_order_defs.svh"

module tb_rsp_order;

    import mem_chan_pkg::*;
    import order_tag_pkg::*;

    localparam logic [15:0] SEED = 16'd20265;
    localparam int N_TXN = 400;
    localparam int LAT_MIN = 2;
    localparam int LAT_SPAN = 12;
    // Watchdog budget of 200 cycles for every transaction of both tests
    localparam int WATCHDOG_CYCLES = 200 * (N_TXN + `RSP_ROB_ENTRIES);

    // One outstanding memory request as the memory model sees it
    typedef struct packed
    {
        rsp_kind_e kind;
        heap_idx_t id;
        mem_addr_t addr;
        logic [31:0] due;
    } pend_t;

    // One accepted read, in client order
    typedef struct packed
    {
        rob_tag_t tag;
        mdata_t mdata;
        mem_addr_t addr;
    } rd_exp_t;

    logic clk = 1'b0;
    logic reset;
    logic rd_req_valid;
    logic rd_req_ready;
    mem_addr_t rd_req_addr;
    mdata_t rd_req_mdata;
    logic wr_req_valid;
    logic wr_req_ready;
    mem_addr_t wr_req_addr;
    mem_data_t wr_req_data;
    mdata_t wr_req_mdata;
    logic mem_rd_valid;
    logic mem_rd_ready;
    mem_addr_t mem_rd_addr;
    rob_tag_t mem_rd_tag;
    logic mem_wr_valid;
    logic mem_wr_ready;
    mem_addr_t mem_wr_addr;
    mem_data_t mem_wr_data;
    heap_idx_t mem_wr_idx;
    logic mem_rsp_valid;
    rsp_hdr_u mem_rsp_hdr;
    mem_data_t mem_rsp_data;
    logic rd_rsp_valid;
    logic rd_rsp_ready;
    mdata_t rd_rsp_mdata;
    mem_data_t rd_rsp_data;
    logic wr_rsp_valid;
    mdata_t wr_rsp_mdata;

    logic [15:0] lfsr_state = SEED;
    logic mem_hold = 1'b0;
    logic mem_rand_ready = 1'b0;
    logic [31:0] cycle_cnt = '0;
    pend_t pend_q [$];
    rd_exp_t rd_exp [$];

    // Scoreboard state that only the compare process writes
    logic [`RSP_ROB_ENTRIES-1:0] rd_busy = '0;
    logic [`RSP_HEAP_ENTRIES-1:0] wr_busy = '0;
    mdata_t wr_mdata_by_idx [`RSP_HEAP_ENTRIES];
    logic wr_due = 1'b0;
    mdata_t wr_due_mdata;
    logic hold_q = 1'b0;
    mdata_t hold_mdata;
    mem_data_t hold_data;
    int rd_accepted = 0;
    int wr_accepted = 0;
    int rd_done = 0;
    int wr_done = 0;

    rsp_order_shim dut0
    (
        .clk(clk), .reset(reset),
        .rd_req_valid(rd_req_valid), .rd_req_ready(rd_req_ready),
        .rd_req_addr(rd_req_addr), .rd_req_mdata(rd_req_mdata),
        .wr_req_valid(wr_req_valid), .wr_req_ready(wr_req_ready),
        .wr_req_addr(wr_req_addr), .wr_req_data(wr_req_data), .wr_req_mdata(wr_req_mdata),
        .mem_rd_valid(mem_rd_valid), .mem_rd_ready(mem_rd_ready),
        .mem_rd_addr(mem_rd_addr), .mem_rd_tag(mem_rd_tag),
        .mem_wr_valid(mem_wr_valid), .mem_wr_ready(mem_wr_ready),
        .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data), .mem_wr_idx(mem_wr_idx),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp_hdr(mem_rsp_hdr), .mem_rsp_data(mem_rsp_data),
        .rd_rsp_valid(rd_rsp_valid), .rd_rsp_ready(rd_rsp_ready),
        .rd_rsp_mdata(rd_rsp_mdata), .rd_rsp_data(rd_rsp_data),
        .wr_rsp_valid(wr_rsp_valid), .wr_rsp_mdata(wr_rsp_mdata)
    );

    always #5 clk = ~clk;

    // ==================================================
    // Helpers
    // ==================================================

    // Fibonacci LFSR with the polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Memory contents as seen by the model
    // The odd multiplier keeps every address bit significant
    function automatic mem_data_t ref_data(input mem_addr_t addr);
        return {addr ^ 16'hc3a5, addr * 16'd40503};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("** Error at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic report_failure(input string why);
        $display("Failure at time %0t: %s", $time, why);
        $display("Result: FAILED");
        $fatal(1, "Protocol failure");
    endtask

    task automatic new_read_request();
        rd_req_addr <= mem_addr_t'(rand_bits(16));
        rd_req_mdata <= mdata_t'(rand_bits(12));
    endtask

    task automatic new_write_request();
        wr_req_addr <= mem_addr_t'(rand_bits(16));
        wr_req_data <= rand_bits(32);
        wr_req_mdata <= mdata_t'(rand_bits(12));
    endtask

    // ==================================================
    // Out-of-order memory model
    // ==================================================

    always @(posedge clk)
    begin : mem_model
        pend_t ent;
        int unsigned k;
        rsp_hdr_u hdr;
        cycle_cnt <= cycle_cnt + 1;
        if (reset)
        begin
            mem_rsp_valid <= 1'b0;
            mem_rd_ready <= 1'b1;
            mem_wr_ready <= 1'b1;
        end
        else
        begin
            // Each accepted request gets its own earliest return cycle
            if (mem_rd_valid && mem_rd_ready)
            begin
                ent.kind = RSP_KIND_RD;
                ent.id = {1'b0, mem_rd_tag};
                ent.addr = mem_rd_addr;
                ent.due = cycle_cnt + LAT_MIN + (rand_bits(4) % LAT_SPAN);
                pend_q.push_back(ent);
            end
            if (mem_wr_valid && mem_wr_ready)
            begin
                ent.kind = RSP_KIND_WR;
                ent.id = mem_wr_idx;
                ent.addr = mem_wr_addr;
                ent.due = cycle_cnt + LAT_MIN + (rand_bits(4) % LAT_SPAN);
                pend_q.push_back(ent);
            end
            mem_rsp_valid <= 1'b0;
            // A random pending entry is picked, and returned only once it is due
            if (!mem_hold && pend_q.size() > 0)
            begin
                k = rand_bits(8) % pend_q.size();
                if (pend_q[k].due <= cycle_cnt)
                begin
                    ent = pend_q[k];
                    pend_q.delete(k);
                    hdr = '0;
                    if (ent.kind == RSP_KIND_RD)
                    begin
                        hdr.rd.kind = RSP_KIND_RD;
                        hdr.rd.tag = ent.id[3:0];
                        mem_rsp_data <= ref_data(ent.addr);
                    end
                    else
                    begin
                        hdr.wr.kind = RSP_KIND_WR;
                        hdr.wr.idx = ent.id;
                        mem_rsp_data <= '0;
                    end
                    mem_rsp_hdr <= hdr;
                    mem_rsp_valid <= 1'b1;
                end
            end
            if (mem_rand_ready)
            begin
                mem_rd_ready <= (rand_bits(3) != 0);
                mem_wr_ready <= (rand_bits(3) != 0);
            end
            else
            begin
                mem_rd_ready <= 1'b1;
                mem_wr_ready <= 1'b1;
            end
        end
    end

    // ==================================================
    // Compare process
    // ==================================================

    always @(posedge clk)
    begin : compare
        rd_exp_t re;
        if (!reset)
        begin
            // Accepted reads pass through with the slot that was free
            if (rd_req_valid && rd_req_ready)
            begin
                check_value("mem_rd_valid on accepted read", 32'(mem_rd_valid), 1);
                check_value("mem_rd_addr", 32'(mem_rd_addr), 32'(rd_req_addr));
                check_value("read tag already in use", 32'(rd_busy[mem_rd_tag]), 0);
                rd_busy[mem_rd_tag] = 1'b1;
                re.tag = mem_rd_tag;
                re.mdata = rd_req_mdata;
                re.addr = rd_req_addr;
                rd_exp.push_back(re);
                rd_accepted++;
            end
            else
                check_value("mem_rd_valid without handshake", 32'(mem_rd_valid), 0);
            if (wr_req_valid && wr_req_ready)
            begin
                check_value("mem_wr_valid on accepted write", 32'(mem_wr_valid), 1);
                check_value("mem_wr_addr", 32'(mem_wr_addr), 32'(wr_req_addr));
                check_value("mem_wr_data", mem_wr_data, wr_req_data);
                check_value("heap index already in use", 32'(wr_busy[mem_wr_idx]), 0);
                wr_busy[mem_wr_idx] = 1'b1;
                wr_mdata_by_idx[mem_wr_idx] = wr_req_mdata;
                wr_accepted++;
            end
            else
                check_value("mem_wr_valid without handshake", 32'(mem_wr_valid), 0);

            // Write response is due exactly one cycle after its memory completion
            check_value("wr_rsp_valid", 32'(wr_rsp_valid), 32'(wr_due));
            if (wr_due)
            begin
                check_value("wr_rsp_mdata", 32'(wr_rsp_mdata), 32'(wr_due_mdata));
                wr_done++;
            end
            wr_due = 1'b0;
            if (mem_rsp_valid && mem_rsp_hdr.wr.kind == RSP_KIND_WR)
            begin
                wr_busy[mem_rsp_hdr.wr.idx] = 1'b0;
                wr_due = 1'b1;
                wr_due_mdata = wr_mdata_by_idx[mem_rsp_hdr.wr.idx];
            end

            // A stalled head must not move
            if (hold_q)
            begin
                check_value("rd_rsp_valid while stalled", 32'(rd_rsp_valid), 1);
                check_value("rd_rsp_mdata while stalled", 32'(rd_rsp_mdata), 32'(hold_mdata));
                check_value("rd_rsp_data while stalled", rd_rsp_data, hold_data);
            end
            hold_q = rd_rsp_valid && !rd_rsp_ready;
            hold_mdata = rd_rsp_mdata;
            hold_data = rd_rsp_data;

            // Reads leave in acceptance order and free their slot on the handshake
            if (rd_rsp_valid && rd_rsp_ready)
            begin
                if (rd_exp.size() == 0)
                    report_failure("read response with no read outstanding");
                re = rd_exp.pop_front();
                check_value("rd_rsp_mdata", 32'(rd_rsp_mdata), 32'(re.mdata));
                check_value("rd_rsp_data", rd_rsp_data, ref_data(re.addr));
                rd_busy[re.tag] = 1'b0;
                rd_done++;
            end
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial
    begin
        int sent;
        int n_full;
        logic stalled;
        reset = 1'b1;
        rd_req_valid = 1'b0;
        rd_req_addr = '0;
        rd_req_mdata = '0;
        wr_req_valid = 1'b0;
        wr_req_addr = '0;
        wr_req_data = '0;
        wr_req_mdata = '0;
        mem_rd_ready = 1'b1;
        mem_wr_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp_hdr = '0;
        mem_rsp_data = '0;
        rd_rsp_ready = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Idle state right after reset
        @(posedge clk);
        check_value("rd_rsp_valid after reset", 32'(rd_rsp_valid), 0);
        check_value("wr_rsp_valid after reset", 32'(wr_rsp_valid), 0);
        check_value("mem_rd_valid after reset", 32'(mem_rd_valid), 0);
        check_value("mem_wr_valid after reset", 32'(mem_wr_valid), 0);
        check_value("rd_req_ready after reset", 32'(rd_req_ready), 1);
        check_value("wr_req_ready after reset", 32'(wr_req_ready), 1);

        // Back-to-back reads with memory and client both stalled fill the buffer
        rd_rsp_ready <= 1'b0;
        mem_hold <= 1'b1;
        rd_req_valid <= 1'b1;
        new_read_request();
        n_full = 0;
        stalled = 1'b0;
        while (!stalled)
        begin
            @(posedge clk);
            if (rd_req_ready)
            begin
                n_full++;
                new_read_request();
            end
            else
                stalled = 1'b1;
        end
        rd_req_valid <= 1'b0;
        check_value("reads accepted before stall", n_full, `RSP_ROB_ENTRIES);
        repeat (10)
        begin
            @(posedge clk);
            check_value("rd_req_ready with buffer full", 32'(rd_req_ready), 0);
            check_value("wr_req_ready with buffer full", 32'(wr_req_ready), 0);
        end
        // Completions alone free nothing until the client takes them
        mem_hold <= 1'b0;
        repeat (40)
        begin
            @(posedge clk);
            check_value("rd_req_ready before consume", 32'(rd_req_ready), 0);
            check_value("wr_req_ready before consume", 32'(wr_req_ready), 0);
        end
        rd_rsp_ready <= 1'b1;
        @(posedge clk);
        while (!rd_req_ready)
            @(posedge clk);

        // Mixed random traffic with random back-pressure on every side
        mem_rand_ready <= 1'b1;
        sent = 0;
        while (sent < N_TXN)
        begin
            @(posedge clk);
            if (rd_req_valid && rd_req_ready)
                sent++;
            if (wr_req_valid && wr_req_ready)
                sent++;
            if (!rd_req_valid || rd_req_ready)
            begin
                rd_req_valid <= (rand_bits(2) != 0) && (sent < N_TXN);
                new_read_request();
            end
            if (!wr_req_valid || wr_req_ready)
            begin
                wr_req_valid <= (rand_bits(2) != 0) && (sent < N_TXN);
                new_write_request();
            end
            rd_rsp_ready <= (rand_bits(2) != 0);
        end
        rd_req_valid <= 1'b0;
        wr_req_valid <= 1'b0;
        rd_rsp_ready <= 1'b1;
        mem_rand_ready <= 1'b0;

        // Drain every outstanding request
        @(negedge clk);
        while (rd_done != rd_accepted || wr_done != wr_accepted || pend_q.size() != 0)
            @(negedge clk);
        repeat (5) @(posedge clk);
        check_value("rd_rsp_valid when idle", 32'(rd_rsp_valid), 0);
        check_value("wr_rsp_valid when idle", 32'(wr_rsp_valid), 0);
        check_value("rd_req_ready when idle", 32'(rd_req_ready), 1);
        check_value("wr_req_ready when idle", 32'(wr_req_ready), 1);
        $display("Result: PASSED");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, traffic did not complete",
                 WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "Timeout");
    end

endmodule

// File: rsp_order_sva.sv
module rsp_order_sva
(
    input  logic clk,
    input  logic reset,
    input  logic rd_req_valid,
    input  logic mem_rd_valid,
    input  logic mem_wr_valid,
    input  logic rd_rsp_valid,
    input  logic rd_rsp_ready,
    input  order_tag_pkg::mdata_t rd_rsp_mdata,
    input  mem_chan_pkg::mem_data_t rd_rsp_data,
    input  logic wr_rsp_valid
);

    // A stalled read response keeps its valid, mdata and data until taken
    rd_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rd_rsp_valid && !rd_rsp_ready |=>
            rd_rsp_valid && $stable(rd_rsp_mdata) && $stable(rd_rsp_data))
        else $error("rd_rsp changed while stalled");

    // Memory requests only ever pass through from a client request
    mem_rd_from_client: assert property (@(posedge clk) mem_rd_valid |-> rd_req_valid)
        else $error("mem_rd_valid without rd_req_valid");

    // Nothing moves toward memory while reset is held
    req_idle_in_reset: assert property (@(posedge clk) reset |-> !mem_rd_valid && !mem_wr_valid)
        else $error("memory request valid during reset");

    // Response valids are registered, so they read low one edge into reset
    rsp_idle_in_reset: assert property (@(posedge clk) reset |=> !rd_rsp_valid && !wr_rsp_valid)
        else $error("client response valid after a reset edge");

endmodule

bind rsp_order_shim rsp_order_sva sva0
(
    .clk(clk),
    .reset(reset),
    .rd_req_valid(rd_req_valid),
    .mem_rd_valid(mem_rd_valid),
    .mem_wr_valid(mem_wr_valid),
    .rd_rsp_valid(rd_rsp_valid),
    .rd_rsp_ready(rd_rsp_ready),
    .rd_rsp_mdata(rd_rsp_mdata),
    .rd_rsp_data(rd_rsp_data),
    .wr_rsp_valid(wr_rsp_valid)
);

// File: rsp_order_shim.sv
module rsp_order_shim
(
    input  logic clk,
    input  logic reset,

    // Client read and write requests
    input  logic rd_req_valid,
    output logic rd_req_ready,
    input  mem_chan_pkg::mem_addr_t rd_req_addr,
    input  order_tag_pkg::mdata_t rd_req_mdata,
    input  logic wr_req_valid,
    output logic wr_req_ready,
    input  mem_chan_pkg::mem_addr_t wr_req_addr,
    input  mem_chan_pkg::mem_data_t wr_req_data,
    input  order_tag_pkg::mdata_t wr_req_mdata,

    // Memory read and write requests
    output logic mem_rd_valid,
    input  logic mem_rd_ready,
    output mem_chan_pkg::mem_addr_t mem_rd_addr,
    output order_tag_pkg::rob_tag_t mem_rd_tag,
    output logic mem_wr_valid,
    input  logic mem_wr_ready,
    output mem_chan_pkg::mem_addr_t mem_wr_addr,
    output mem_chan_pkg::mem_data_t mem_wr_data,
    output order_tag_pkg::heap_idx_t mem_wr_idx,

    // Shared memory response channel, no back-pressure
    input  logic mem_rsp_valid,
    input  mem_chan_pkg::rsp_hdr_u mem_rsp_hdr,
    input  mem_chan_pkg::mem_data_t mem_rsp_data,

    // Client responses
    output logic rd_rsp_valid,
    input  logic rd_rsp_ready,
    output order_tag_pkg::mdata_t rd_rsp_mdata,
    output mem_chan_pkg::mem_data_t rd_rsp_data,
    output logic wr_rsp_valid,
    output order_tag_pkg::mdata_t wr_rsp_mdata
);

    import mem_chan_pkg::*;
    import order_tag_pkg::*;

    logic rob_full;
    logic heap_full;
    logic rob_alloc;
    logic heap_alloc;
    rob_tag_t rob_alloc_tag;
    heap_idx_t heap_alloc_idx;
    logic rd_fill_valid;
    logic wr_free_valid;

    // ==================================================
    // Response header decode
    // ==================================================

    // The kind bit picks which view of the header word is meaningful
    assign rd_fill_valid = mem_rsp_valid && (mem_rsp_hdr.rd.kind == RSP_KIND_RD);
    assign wr_free_valid = mem_rsp_valid && (mem_rsp_hdr.wr.kind == RSP_KIND_WR);

    rsp_order_ctrl ctrl0
    (
        .clk(clk),
        .reset(reset),
        .rd_req_valid(rd_req_valid),
        .rd_req_ready(rd_req_ready),
        .rd_req_addr(rd_req_addr),
        .wr_req_valid(wr_req_valid),
        .wr_req_ready(wr_req_ready),
        .wr_req_addr(wr_req_addr),
        .wr_req_data(wr_req_data),
        .mem_rd_valid(mem_rd_valid),
        .mem_rd_ready(mem_rd_ready),
        .mem_rd_addr(mem_rd_addr),
        .mem_rd_tag(mem_rd_tag),
        .mem_wr_valid(mem_wr_valid),
        .mem_wr_ready(mem_wr_ready),
        .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data),
        .mem_wr_idx(mem_wr_idx),
        .rob_full(rob_full),
        .heap_full(heap_full),
        .rob_alloc_tag(rob_alloc_tag),
        .heap_alloc_idx(heap_alloc_idx),
        .rob_alloc(rob_alloc),
        .heap_alloc(heap_alloc)
    );

    // Reads come back sorted, with the client mdata restored from the slot
    rd_reorder_buf rob0
    (
        .clk(clk),
        .reset(reset),
        .alloc(rob_alloc),
        .alloc_mdata(rd_req_mdata),
        .alloc_tag(rob_alloc_tag),
        .full(rob_full),
        .fill_valid(rd_fill_valid),
        .fill_tag(mem_rsp_hdr.rd.tag),
        .fill_data(mem_rsp_data),
        .rsp_valid(rd_rsp_valid),
        .rsp_ready(rd_rsp_ready),
        .rsp_mdata(rd_rsp_mdata),
        .rsp_data(rd_rsp_data)
    );

    // Writes complete in memory order, each with its own saved mdata
    wr_mdata_heap heap0
    (
        .clk(clk),
        .reset(reset),
        .alloc(heap_alloc),
        .alloc_mdata(wr_req_mdata),
        .alloc_idx(heap_alloc_idx),
        .full(heap_full),
        .free_valid(wr_free_valid),
        .free_idx(mem_rsp_hdr.wr.idx),
        .rsp_valid(wr_rsp_valid),
        .rsp_mdata(wr_rsp_mdata)
    );

endmodule

// File: wr_mdata_heap.sv
`include "rsp_order_defs.svh"

module wr_mdata_heap
(
    input  logic clk,
    input  logic reset,

    // Allocation for a write request
    input  logic alloc,
    input  order_tag_pkg::mdata_t alloc_mdata,
    output order_tag_pkg::heap_idx_t alloc_idx,
    output logic full,

    // Write completion from memory
    input  logic free_valid,
    input  order_tag_pkg::heap_idx_t free_idx,

    // Write response toward the client, one cycle after the completion
    output logic rsp_valid,
    output order_tag_pkg::mdata_t rsp_mdata
);

    import order_tag_pkg::*;

    // Count of free indices, wide enough to hold all of them
    typedef logic [`RSP_HEAP_IDX_BITS:0] heap_cnt_t;

    heap_idx_t free_list [`RSP_HEAP_ENTRIES];
    heap_idx_t pop_ptr;
    heap_idx_t push_ptr;
    heap_cnt_t free_cnt;
    mdata_t mdata_ram [`RSP_HEAP_ENTRIES];

    // The next free index is always at the front of the list
    assign alloc_idx = free_list[pop_ptr];

    // One index stays in reserve for the registered full flag in the controller
    assign full = (free_cnt <= heap_cnt_t'(1));

    // ==================================================
    // Free list
    // ==================================================

    // After reset the list holds every index, so push and pop pointers meet
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `RSP_HEAP_ENTRIES; i++)
                free_list[i] <= heap_idx_t'(i);
            pop_ptr <= '0;
            push_ptr <= '0;
            free_cnt <= heap_cnt_t'(`RSP_HEAP_ENTRIES);
            rsp_valid <= 1'b0;
        end
        else
        begin
            if (alloc)
                pop_ptr <= pop_ptr + 1'b1;
            if (free_valid)
            begin
                free_list[push_ptr] <= free_idx;
                push_ptr <= push_ptr + 1'b1;
            end
            case ({alloc, free_valid})
                2'b10: free_cnt <= free_cnt - 1'b1;
                2'b01: free_cnt <= free_cnt + 1'b1;
                default: free_cnt <= free_cnt;
            endcase
            rsp_valid <= free_valid;
        end
    end

    // Saved mdata, read back registered when its index is freed
    always_ff @(posedge clk)
    begin
        if (alloc)
            mdata_ram[alloc_idx] <= alloc_mdata;
        if (free_valid)
            rsp_mdata <= mdata_ram[free_idx];
    end

endmodule

// File: rd_reorder_buf.sv
`include "rsp_order_defs.svh"

module rd_reorder_buf
(
    input  logic clk,
    input  logic reset,

    // Allocation in request order
    input  logic alloc,
    input  order_tag_pkg::mdata_t alloc_mdata,
    output order_tag_pkg::rob_tag_t alloc_tag,
    output logic full,

    // Data return from memory, in any order
    input  logic fill_valid,
    input  order_tag_pkg::rob_tag_t fill_tag,
    input  mem_chan_pkg::mem_data_t fill_data,

    // Sorted response toward the client
    output logic rsp_valid,
    input  logic rsp_ready,
    output order_tag_pkg::mdata_t rsp_mdata,
    output mem_chan_pkg::mem_data_t rsp_data
);

    import order_tag_pkg::*;
    import mem_chan_pkg::*;

    // Pointers carry one extra bit so that a full ring differs from an empty one
    typedef logic [`RSP_ROB_TAG_BITS:0] rob_ptr_t;

    // Full is raised with one slot still free, for the lag in the controller
    localparam rob_ptr_t FULL_LEVEL = rob_ptr_t'(`RSP_ROB_ENTRIES - 1);

    rob_ptr_t tail_ptr;
    rob_ptr_t head_ptr;
    rob_ptr_t used;
    rob_tag_t head_slot;
    logic release_head;
    logic [`RSP_ROB_ENTRIES-1:0] arrived;

    mdata_t mdata_ram [`RSP_ROB_ENTRIES];
    mem_data_t data_ram [`RSP_ROB_ENTRIES];

    assign alloc_tag = tail_ptr[`RSP_ROB_TAG_BITS-1:0];
    assign head_slot = head_ptr[`RSP_ROB_TAG_BITS-1:0];
    assign used = tail_ptr - head_ptr;
    assign full = (used >= FULL_LEVEL);

    // ==================================================
    // Slot control
    // ==================================================

    // Slots that were never allocated keep a clear arrived bit, so the head
    // bit alone tells whether the oldest read has its data
    assign rsp_valid = arrived[head_slot];
    assign release_head = rsp_valid && rsp_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tail_ptr <= '0;
            head_ptr <= '0;
            arrived <= '0;
        end
        else
        begin
            if (alloc)
                tail_ptr <= tail_ptr + 1'b1;
            if (release_head)
                head_ptr <= head_ptr + 1'b1;
            // A fill never targets the head while it is being released,
            // since the head already holds its data
            if (fill_valid)
                arrived[fill_tag] <= 1'b1;
            if (release_head)
                arrived[head_slot] <= 1'b0;
        end
    end

    // ==================================================
    // Payload storage
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (alloc)
            mdata_ram[alloc_tag] <= alloc_mdata;
        if (fill_valid)
            data_ram[fill_tag] <= fill_data;
    end

    // The head is read straight from the arrays and held while the client stalls
    assign rsp_mdata = mdata_ram[head_slot];
    assign rsp_data = data_ram[head_slot];

endmodule

// File: rsp_order_ctrl.sv
module rsp_order_ctrl
(
    input  logic clk,
    input  logic reset,

    // Client requests
    input  logic rd_req_valid,
    output logic rd_req_ready,
    input  mem_chan_pkg::mem_addr_t rd_req_addr,
    input  logic wr_req_valid,
    output logic wr_req_ready,
    input  mem_chan_pkg::mem_addr_t wr_req_addr,
    input  mem_chan_pkg::mem_data_t wr_req_data,

    // Memory requests
    output logic mem_rd_valid,
    input  logic mem_rd_ready,
    output mem_chan_pkg::mem_addr_t mem_rd_addr,
    output order_tag_pkg::rob_tag_t mem_rd_tag,
    output logic mem_wr_valid,
    input  logic mem_wr_ready,
    output mem_chan_pkg::mem_addr_t mem_wr_addr,
    output mem_chan_pkg::mem_data_t mem_wr_data,
    output order_tag_pkg::heap_idx_t mem_wr_idx,

    // Reorder buffer and heap allocation
    input  logic rob_full,
    input  logic heap_full,
    input  order_tag_pkg::rob_tag_t rob_alloc_tag,
    input  order_tag_pkg::heap_idx_t heap_alloc_idx,
    output logic rob_alloc,
    output logic heap_alloc
);

    logic rob_full_q;
    logic heap_full_q;
    logic chan_open;

    // Full flags are registered to keep the path from the buffer counters off
    // the request handshake. Each structure keeps one reserve slot, which
    // absorbs the single allocation that can slip through during the lag
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rob_full_q <= 1'b0;
            heap_full_q <= 1'b0;
        end
        else
        begin
            rob_full_q <= rob_full;
            heap_full_q <= heap_full;
        end
    end

    // ==================================================
    // Channel synchronization
    // ==================================================

    // Both channels open and close together so that loads and stores keep
    // their relative order. Either memory port or either structure stalls both
    assign chan_open = mem_rd_ready && mem_wr_ready && !rob_full_q && !heap_full_q;

    assign rd_req_ready = chan_open;
    assign wr_req_ready = chan_open;

    // A request only reaches memory on a cycle the shim can also allocate,
    // so a memory handshake and an allocation are always the same event
    assign mem_rd_valid = rd_req_valid && chan_open;
    assign mem_wr_valid = wr_req_valid && chan_open;

    assign rob_alloc = mem_rd_valid;
    assign heap_alloc = mem_wr_valid;

    // ==================================================
    // Request rewriting
    // ==================================================

    // The client mdata is replaced by the slot or index allocated this cycle
    assign mem_rd_addr = rd_req_addr;
    assign mem_rd_tag = rob_alloc_tag;
    assign mem_wr_addr = wr_req_addr;
    assign mem_wr_data = wr_req_data;
    assign mem_wr_idx = heap_alloc_idx;

endmodule

// File: mem_chan_pkg.sv
`include "rsp_order_defs.svh"

package mem_chan_pkg;

    // Address and data words on the memory port
    typedef logic [`RSP_ADDR_BITS-1:0] mem_addr_t;
    typedef logic [`RSP_DATA_BITS-1:0] mem_data_t;

    // Kind of completion carried on the shared response channel
    typedef enum logic
    {
        RSP_KIND_RD = 1'b0,
        RSP_KIND_WR = 1'b1
    } rsp_kind_e;

    // Read view of the response header
    // The spare bit pads the tag up to the width of the heap index
    typedef struct packed
    {
        rsp_kind_e kind;
        logic spare;
        order_tag_pkg::rob_tag_t tag;
    } rsp_hdr_rd_t;

    // Write view of the response header
    typedef struct packed
    {
        rsp_kind_e kind;
        order_tag_pkg::heap_idx_t idx;
    } rsp_hdr_wr_t;

    // One 6-bit header word, decoded through the view that its top bit selects
    // The kind sits in the same place in both views
    typedef union packed
    {
        rsp_hdr_rd_t rd;
        rsp_hdr_wr_t wr;
    } rsp_hdr_u;

endpackage

// File: order_tag_pkg.sv
`include "rsp_order_defs.svh"

package order_tag_pkg;

    // Slot number in the read reorder buffer
    // It replaces the client mdata on the memory read request
    typedef logic [`RSP_ROB_TAG_BITS-1:0] rob_tag_t;

    // Index into the write metadata heap
    // It replaces the client mdata on the memory write request
    typedef logic [`RSP_HEAP_IDX_BITS-1:0] heap_idx_t;

    // Client metadata, opaque to the shim
    // The shim stores it and returns it unchanged with the response
    typedef logic [`RSP_MDATA_BITS-1:0] mdata_t;

endpackage

// File: rsp_order_defs.svh
`ifndef RSP_ORDER_DEFS_SVH
`define RSP_ORDER_DEFS_SVH

// ==================================================
// Reorder buffer sizing
// ==================================================

// Number of reads that may be outstanding toward memory
`define RSP_ROB_ENTRIES 16
// Width of a reorder slot number
`define RSP_ROB_TAG_BITS 4

// ==================================================
// Write metadata heap sizing
// ==================================================

// Number of writes that may be outstanding toward memory
`define RSP_HEAP_ENTRIES 32
// Width of a heap index
`define RSP_HEAP_IDX_BITS 5

// ==================================================
// Field widths on the client and memory sides
// ==================================================

`define RSP_MDATA_BITS 12
`define RSP_ADDR_BITS 16
`define RSP_DATA_BITS 32

`endif
